// ==== src/spi_consts.svh ====
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// frame field widths
`define SPI_ADDR_WIDTH 15
`define SPI_DATA_WIDTH 16

// address + rw bit + data
`define SPI_FRAME_BITS 32

// run-time clock divider
`define SPI_DIV_WIDTH 16

`endif

// ==== src/spi_pkg.sv ====
`include "spi_consts.svh"

package spi_pkg;

    typedef logic [`SPI_ADDR_WIDTH-1:0] spi_addr_t;
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_data_t;
    typedef logic [`SPI_FRAME_BITS-1:0] spi_frame_t;
    typedef logic [`SPI_DIV_WIDTH-1:0]  spi_div_t;

    // quarter phase within one frame bit
    typedef logic [1:0] spi_phase_t;
    // frame bit position, one spare bit so it can count past the end
    typedef logic [5:0] spi_bit_idx_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SELECT,
        SEQ_SHIFT,
        SEQ_STOP,
        SEQ_ACK
    } spi_state_e;

endpackage

// ==== src/spi_tick_timer.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_tick_timer
    import spi_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  spi_div_t   i_divider,
    input  logic       i_phase_run,
    input  logic       i_bit_clear,
    output logic       o_tick,
    output spi_phase_t o_phase,
    output logic       o_last_bit
);

    spi_div_t     div_cnt;
    spi_phase_t   phase;
    spi_bit_idx_t bit_idx;

    ////////////////////////////////////////
    // divider tick
    ////////////////////////////////////////

    // >= keeps the counter sane if the divider shrinks mid count
    assign o_tick = (div_cnt >= i_divider);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            div_cnt <= '0;
        end else if (o_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // quarter phase and bit position
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst || i_bit_clear) begin
            phase   <= '0;
            bit_idx <= '0;
        end else if (o_tick && i_phase_run) begin
            phase <= phase + 1'b1;
            // next bit once phase 3 wraps
            if (phase == 2'd3) begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    assign o_phase    = phase;
    assign o_last_bit = (bit_idx == spi_bit_idx_t'(`SPI_FRAME_BITS - 1));

endmodule

// ==== src/spi_sequencer.sv ====
`timescale 1ns/1ps

module spi_sequencer
    import spi_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_req,
    input  logic       i_cpol,
    input  logic       i_cpha,
    input  logic       i_tick,
    input  spi_phase_t i_phase,
    input  logic       i_last_bit,
    output logic       o_ack,
    output logic       o_ss,
    output logic       o_sclk,
    output logic       o_phase_run,
    output logic       o_bit_clear,
    output logic       o_load,
    output logic       o_launch,
    output logic       o_sample,
    output logic       o_release
);

    spi_state_e state;
    logic       cpol_q;
    logic       cpha_q;
    logic       sclk;
    // high during bit 0, where cpha 1 has nothing to sample yet
    logic       first_bit;

    ////////////////////////////////////////
    // state register and slow outputs
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= SEQ_IDLE;
            cpol_q    <= 1'b0;
            cpha_q    <= 1'b0;
            sclk      <= 1'b0;
            first_bit <= 1'b0;
            o_ack     <= 1'b0;
            o_ss      <= 1'b1;
        end else if (i_tick) begin
            case (state)
                SEQ_IDLE: begin
                    if (i_req) begin
                        cpol_q <= i_cpol;
                        cpha_q <= i_cpha;
                        o_ss   <= 1'b0;
                        state  <= SEQ_SELECT;
                    end
                end
                SEQ_SELECT: begin
                    first_bit <= 1'b1;
                    state     <= SEQ_SHIFT;
                end
                SEQ_SHIFT: begin
                    if (i_phase == 2'd1) begin
                        sclk <= 1'b1;
                    end
                    if (i_phase == 2'd3) begin
                        sclk      <= 1'b0;
                        first_bit <= 1'b0;
                        if (i_last_bit) begin
                            state <= SEQ_STOP;
                        end
                    end
                end
                SEQ_STOP: begin
                    if (i_phase == 2'd1) begin
                        o_ss <= 1'b1;
                    end
                    if (i_phase == 2'd3) begin
                        o_ack <= 1'b1;
                        state <= SEQ_ACK;
                    end
                end
                SEQ_ACK: begin
                    // hold ack until the host drops its request
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign o_sclk = sclk ^ cpol_q;

    ////////////////////////////////////////
    // shifter strobes, one cycle on a tick
    ////////////////////////////////////////

    always_comb begin
        o_load      = 1'b0;
        o_launch    = 1'b0;
        o_sample    = 1'b0;
        o_release   = 1'b0;
        o_bit_clear = 1'b0;
        o_phase_run = (state == SEQ_SHIFT) || (state == SEQ_STOP);
        if (i_tick) begin
            case (state)
                SEQ_IDLE:   o_load = i_req;
                SEQ_SELECT: begin
                    o_bit_clear = 1'b1;
                    // cpha 0 needs bit 0 on MOSI before the first edge
                    o_launch    = !cpha_q;
                end
                SEQ_SHIFT: begin
                    case (i_phase)
                        2'd0:    o_sample = cpha_q && !first_bit;
                        2'd1:    o_launch = cpha_q;
                        2'd2:    o_sample = !cpha_q;
                        default: o_launch = !cpha_q && !i_last_bit;
                    endcase
                end
                SEQ_STOP: begin
                    // trailing sample of the last bit for cpha 1
                    o_sample  = (i_phase == 2'd0) && cpha_q;
                    o_release = (i_phase == 2'd1);
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/spi_shifter.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shifter
    import spi_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_load,
    input  logic      i_launch,
    input  logic      i_sample,
    input  logic      i_release,
    input  spi_addr_t i_addr,
    input  logic      i_rw,
    input  spi_data_t i_data,
    input  logic      i_miso,
    output logic      o_mosi,
    output spi_data_t o_read_data
);

    spi_frame_t frame;
    // only the data field of the received frame is kept
    spi_data_t  rx;

    ////////////////////////////////////////
    // transmit side
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            // reads send zeros in the data field
            frame <= {i_addr, i_rw, (i_rw ? spi_data_t'(0) : i_data)};
        end else if (i_launch) begin
            frame <= {frame[`SPI_FRAME_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mosi <= 1'b0;
        end else if (i_release) begin
            o_mosi <= 1'b0;
        end else if (i_launch) begin
            o_mosi <= frame[`SPI_FRAME_BITS-1];
        end
    end

    ////////////////////////////////////////
    // receive side
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_sample) begin
            rx <= {rx[`SPI_DATA_WIDTH-2:0], i_miso};
        end
    end

    // last 16 samples become the read word
    always_ff @(posedge i_clk) begin
        if (i_release) begin
            o_read_data <= rx;
        end
    end

endmodule

// ==== src/spi_master_top.sv ====
`timescale 1ns/1ps

module spi_master_top
    import spi_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_req,
    input  spi_addr_t i_addr,
    input  logic      i_rw,
    input  spi_data_t i_data,
    input  logic      i_cpol,
    input  logic      i_cpha,
    input  spi_div_t  i_divider,
    input  logic      i_miso,
    output logic      o_ack,
    output spi_data_t o_read_data,
    output logic      o_ss,
    output logic      o_sclk,
    output logic      o_mosi
);

    logic       tick;
    spi_phase_t phase;
    logic       last_bit;
    logic       phase_run;
    logic       bit_clear;
    logic       load_stb;
    logic       launch_stb;
    logic       sample_stb;
    logic       release_stb;

    spi_tick_timer timer_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_divider   (i_divider),
        .i_phase_run (phase_run),
        .i_bit_clear (bit_clear),
        .o_tick      (tick),
        .o_phase     (phase),
        .o_last_bit  (last_bit)
    );

    spi_sequencer sequencer_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_cpol      (i_cpol),
        .i_cpha      (i_cpha),
        .i_tick      (tick),
        .i_phase     (phase),
        .i_last_bit  (last_bit),
        .o_ack       (o_ack),
        .o_ss        (o_ss),
        .o_sclk      (o_sclk),
        .o_phase_run (phase_run),
        .o_bit_clear (bit_clear),
        .o_load      (load_stb),
        .o_launch    (launch_stb),
        .o_sample    (sample_stb),
        .o_release   (release_stb)
    );

    spi_shifter shifter_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_load      (load_stb),
        .i_launch    (launch_stb),
        .i_sample    (sample_stb),
        .i_release   (release_stb),
        .i_addr      (i_addr),
        .i_rw        (i_rw),
        .i_data      (i_data),
        .i_miso      (i_miso),
        .o_mosi      (o_mosi),
        .o_read_data (o_read_data)
    );

endmodule

// ==== verif/spi_slave_model.sv ====
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_slave_model
    import spi_pkg::*;
(
    input  logic       i_ss,
    input  logic       i_sclk,
    input  logic       i_mosi,
    input  logic       i_cpol,
    input  logic       i_cpha,
    input  spi_frame_t i_resp,
    output logic       o_miso,
    output spi_frame_t o_rx_frame,
    output int         o_rx_bits
);

    spi_frame_t tx = '0;
    spi_frame_t rx = '0;
    spi_frame_t rx_done = '0;
    int         bits = 0;
    int         bits_done = 0;
    logic       active = 1'b0;
    logic       miso = 1'b0;
    // clock level with the polarity taken out, 1 after a leading edge
    logic       lvl;
    logic       last_lvl = 1'b0;

    assign o_miso     = miso;
    assign o_rx_frame = rx_done;
    assign o_rx_bits  = bits_done;

    // next response bit onto MISO
    task automatic shift_out;
        miso = tx[`SPI_FRAME_BITS-1];
        tx   = tx << 1;
    endtask

    task automatic capture_in;
        rx   = {rx[`SPI_FRAME_BITS-2:0], i_mosi};
        bits = bits + 1;
    endtask

    always @(i_ss or i_sclk) begin
        lvl = i_sclk ^ i_cpol;
        if (i_ss !== 1'b0) begin
            // frame over, expose what came in
            if (active) begin
                rx_done   = rx;
                bits_done = bits;
                active    = 1'b0;
            end
        end else if (!active) begin
            active   = 1'b1;
            last_lvl = 1'b0;
            bits     = 0;
            rx       = '0;
            tx       = i_resp;
            // cpha 0 needs the MSB out before the first edge
            if (!i_cpha) begin
                shift_out();
            end
        end else if (lvl != last_lvl) begin
            last_lvl = lvl;
            // capture on leading edge for cpha 0, trailing for cpha 1
            if (lvl ^ i_cpha) begin
                capture_in();
            end else begin
                shift_out();
            end
        end
    end

endmodule

// ==== verif/tb_spi_master.sv ====
`timescale 1ns/1ps

module tb_spi_master
    import spi_pkg::*;
();

    // 12 transfers x 136 ticks x 4 cycles, rounded up
    localparam int CYCLE_LIMIT = 8000;

    logic       clk;
    logic       rst;
    logic       req;
    spi_addr_t  addr;
    logic       rw;
    spi_data_t  wdata;
    logic       cpol;
    logic       cpha;
    spi_div_t   divider;
    logic       miso;
    logic       ack;
    spi_data_t  read_data;
    logic       ss;
    logic       sclk;
    logic       mosi;
    spi_frame_t resp;
    spi_frame_t rx_frame;
    int         rx_bits;

    logic [31:0] lfsr = 32'hc7942a88;
    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;

    // bus monitor state
    logic prev_ss;
    logic prev_sclk;
    logic prev_ack;
    logic prev_req;
    logic in_xfer;
    int   rise_cnt;
    int   fall_cnt;
    int   half_cycles;
    int   ss_windows;

    spi_master_top dut_i (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req       (req),
        .i_addr      (addr),
        .i_rw        (rw),
        .i_data      (wdata),
        .i_cpol      (cpol),
        .i_cpha      (cpha),
        .i_divider   (divider),
        .i_miso      (miso),
        .o_ack       (ack),
        .o_read_data (read_data),
        .o_ss        (ss),
        .o_sclk      (sclk),
        .o_mosi      (mosi)
    );

    spi_slave_model slave_i (
        .i_ss       (ss),
        .i_sclk     (sclk),
        .i_mosi     (mosi),
        .i_cpol     (cpol),
        .i_cpha     (cpha),
        .i_resp     (resp),
        .o_miso     (miso),
        .o_rx_frame (rx_frame),
        .o_rx_bits  (rx_bits)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic log_error(input string msg);
        err_count = err_count + 1;
        $display("ERR %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // one request/ack transfer
    ////////////////////////////////////////

    task automatic run_transfer(input string name, input logic is_read, input logic pol,
                                input logic pha, input int div_sel);
        logic [31:0] rnd;
        spi_frame_t  expected;
        int          errs_before;
        errs_before = err_count;
        @(negedge clk);
        draw_bits(15, rnd);
        addr = rnd[14:0];
        draw_bits(16, rnd);
        wdata = rnd[15:0];
        draw_bits(32, rnd);
        resp = rnd;
        if (div_sel < 0) begin
            draw_bits(2, rnd);
            divider = spi_div_t'(rnd[1:0]);
        end else begin
            divider = spi_div_t'(div_sel);
        end
        rw   = is_read;
        cpol = pol;
        cpha = pha;
        req  = 1'b1;
        while (!ack) begin
            @(negedge clk);
        end
        // address, rw bit, then write data or zeros
        expected = {addr, is_read, is_read ? 16'h0000 : wdata};
        assert (rx_frame == expected) else
            log_error($sformatf("%s frame %h, expected %h", name, rx_frame, expected));
        assert (rx_bits == 32) else
            log_error($sformatf("%s slave counted %0d bits", name, rx_bits));
        if (is_read) begin
            assert (read_data == resp[15:0]) else
                log_error($sformatf("read word %h, expected %h", read_data, resp[15:0]));
        end
        req = 1'b0;
        while (ack) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (err_count == errs_before) begin
            pass_count = pass_count + 1;
            $display("%s cpol=%0d cpha=%0d div=%0d: ok", name, pol, pha, divider);
        end else begin
            fail_count = fail_count + 1;
            $display("%s cpol=%0d cpha=%0d div=%0d: mismatch", name, pol, pha, divider);
        end
    endtask

    initial begin
        logic [1:0] mode;
        rst     = 1'b1;
        req     = 1'b0;
        addr    = '0;
        rw      = 1'b0;
        wdata   = '0;
        cpol    = 1'b0;
        cpha    = 1'b0;
        divider = '0;
        resp    = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (ss === 1'b1 && mosi === 1'b0) else
            log_error("slave select or MOSI not idle after reset");
        for (int m = 0; m < 4; m++) begin
            mode = m[1:0];
            run_transfer("write", 1'b0, mode[1], mode[0], -1);
            run_transfer("read", 1'b1, mode[1], mode[0], -1);
            run_transfer("divider", mode[0] ^ mode[1], mode[1], mode[0], mode[0] ? 3 : 0);
        end
        $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // framing and handshake monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            in_xfer    = 1'b0;
            ss_windows = 0;
        end else begin
            half_cycles = half_cycles + 1;
            if (prev_ss && !ss) begin
                assert (!ack) else log_error("slave select fell while ack was high");
                rise_cnt    = 0;
                fall_cnt    = 0;
                half_cycles = 0;
                in_xfer     = 1'b1;
                ss_windows  = ss_windows + 1;
            end
            if (!prev_ss && !ss && (sclk != prev_sclk)) begin
                if (sclk) begin
                    rise_cnt = rise_cnt + 1;
                end else begin
                    fall_cnt = fall_cnt + 1;
                end
                assert (half_cycles >= 2 * (divider + 1)) else
                    log_error($sformatf("SPI clock half period of %0d cycles", half_cycles));
                half_cycles = 0;
            end
            if (!prev_ss && ss) begin
                assert (rise_cnt == 32 && fall_cnt == 32) else
                    log_error($sformatf("%0d rising, %0d falling SPI clock edges",
                                        rise_cnt, fall_cnt));
            end
            if (in_xfer && ss) begin
                assert (sclk == cpol) else log_error("idle SPI clock differs from cpol");
            end
            // request level at the edge where ack changed
            if (ack && !prev_ack) begin
                assert (prev_req) else log_error("ack rose without a request");
                assert (ss_windows == 1) else
                    log_error($sformatf("%0d slave select windows in one transfer",
                                        ss_windows));
                ss_windows = 0;
            end
            if (!ack && prev_ack) begin
                assert (!prev_req) else log_error("ack fell while request was high");
                in_xfer = 1'b0;
            end
            assert (!ack || ss) else log_error("slave select low while ack was high");
        end
        prev_ss   = ss;
        prev_sclk = sclk;
        prev_ack  = ack;
        prev_req  = req;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: transfers did not finish within %0d clock cycles",
                     CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/spi_pkg.sv
src/spi_tick_timer.sv
src/spi_sequencer.sv
src/spi_shifter.sv
src/spi_master_top.sv
verif/spi_slave_model.sv
verif/tb_spi_master.sv
